// File: burst_tester_regs.f
hw/axil_pkg.sv
hw/tester_regs_pkg.sv
hw/axil_write_channel.sv
hw/axil_read_channel.sv
hw/tester_reg_bank.sv
hw/burst_tester_regs.sv
verification/burst_tester_regs_props.sv
verification/tb_burst_tester_regs.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_burst_tester_regs \
    -f burst_tester_regs.f \
    -o tb_burst_tester_regs

sim_output=$(./obj_dir/tb_burst_tester_regs) || true
echo "$sim_output"

if echo "$sim_output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: verification/tb_burst_tester_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_burst_tester_regs;
    import axil_pkg::*;
    import tester_regs_pkg::*;

    // About 200 transactions of up to 12 cycles, with margin
    localparam int CYCLE_LIMIT = 4000;

    // One read as seen on the bus, next to what the model expects
    typedef struct packed {
        reg_idx_e               index;
        logic [AXIL_DATA_W-1:0] got;
        logic [AXIL_DATA_W-1:0] exp;
        axil_resp_e             resp;
        tester_ctrl_t           ctrl_got;
        tester_ctrl_t           ctrl_exp;
    } read_result_t;

    logic           S_AXI_ACLK;
    logic           S_AXI_ARESETN;
    axil_wr_req_t   wr_req;
    axil_wr_rsp_t   wr_rsp;
    axil_rd_req_t   rd_req;
    axil_rd_rsp_t   rd_rsp;
    tester_status_t status;
    tester_ctrl_t   ctrl;

    // Model of the stored registers
    logic [AXIL_DATA_W-1:0] shadow [8];
    reg_idx_e               writable [5];
    logic [31:0]            rng_state;
    read_result_t           last_read;
    event                   read_ready;
    int                     cycles = 0;
    int                     bus_errors = 0;
    int                     cmp_errors = 0;
    int                     checks = 0;

    burst_tester_regs u_burst_tester_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_req        (wr_req),
        .wr_rsp        (wr_rsp),
        .rd_req        (rd_req),
        .rd_rsp        (rd_rsp),
        .status        (status),
        .ctrl          (ctrl)
    );

    // 8 ns clock
    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // --------------------
    // Model
    // --------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Handshake delay of 0 to 3 cycles, from the upper bits
    function automatic int random_delay();
        logic [31:0] r;
        r = next_random();
        return int'(r[17:16]);
    endfunction

    function automatic logic [AXIL_DATA_W-1:0] expected_read(
        input reg_idx_e               idx,
        input logic [AXIL_DATA_W-1:0] regs [8],
        input tester_status_t         st
    );
        case (idx)
            // Status flags are live, zero extended
            REG_DONE:    return AXIL_DATA_W'(st.txn_done);
            REG_ERROR:   return AXIL_DATA_W'(st.txn_error);
            REG_UNUSED:  return '0;
            REG_PG_SEED: return SIGNATURE;
            default:     return regs[idx];
        endcase
    endfunction

    function automatic tester_ctrl_t expected_ctrl();
        tester_ctrl_t c;
        c.init_txn  = shadow[REG_CTRL][0];
        c.m_address = shadow[REG_ADDR];
        c.pg_mode   = shadow[REG_PG_MODE][PG_MODE_W-1:0];
        c.pg_seed   = shadow[REG_PG_SEED];
        return c;
    endfunction

    // Byte lanes under the strobe, read-only slots untouched
    function automatic void update_shadow(
        input reg_idx_e               idx,
        input logic [AXIL_DATA_W-1:0] data,
        input logic [AXIL_STRB_W-1:0] strb
    );
        if (idx inside {REG_CTRL, REG_ADDR, REG_CANARY, REG_PG_MODE, REG_PG_SEED})
        begin
            for (int i = 0; i < AXIL_STRB_W; i++)
            begin
                if (strb[i])
                begin
                    shadow[idx][i*8 +: 8] = data[i*8 +: 8];
                end
            end
        end
    endfunction

    // --------------------
    // Bus tasks
    // --------------------

    task automatic axil_write(
        input reg_idx_e               idx,
        input logic [AXIL_DATA_W-1:0] data,
        input logic [AXIL_STRB_W-1:0] strb
    );
        int delay;
        delay = random_delay();
        @(negedge S_AXI_ACLK);
        wr_req.awaddr  = {idx, 2'b00};
        wr_req.awvalid = 1'b1;
        wr_req.wdata   = data;
        wr_req.wstrb   = strb;
        wr_req.wvalid  = 1'b1;
        do
        begin
            @(negedge S_AXI_ACLK);
        end
        while (!wr_rsp.awready);
        // Beat taken at the edge after the ready pulse
        @(negedge S_AXI_ACLK);
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        while (!wr_rsp.bvalid)
        begin
            @(negedge S_AXI_ACLK);
        end
        if (wr_rsp.bresp !== RESP_OKAY)
        begin
            bus_errors++;
            $display("FAILED %0t: write index %0d bresp %0d, expected OKAY",
                $time, idx, wr_rsp.bresp);
        end
        update_shadow(idx, data, strb);
        // Offer the same beat again while the response waits
        repeat (delay)
        begin
            wr_req.awvalid = 1'b1;
            wr_req.wvalid  = 1'b1;
            @(negedge S_AXI_ACLK);
            if (wr_rsp.awready)
            begin
                bus_errors++;
                $display("FAILED %0t: write accepted while a response was pending", $time);
            end
        end
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        wr_req.bready  = 1'b1;
        @(negedge S_AXI_ACLK);
        wr_req.bready = 1'b0;
        if (wr_rsp.bvalid)
        begin
            bus_errors++;
            $display("FAILED %0t: bvalid still high after the response was taken", $time);
        end
    endtask

    task automatic axil_read(input reg_idx_e idx);
        int delay;
        delay = random_delay();
        @(negedge S_AXI_ACLK);
        rd_req.araddr  = {idx, 2'b00};
        rd_req.arvalid = 1'b1;
        do
        begin
            @(negedge S_AXI_ACLK);
        end
        while (!rd_rsp.arready);
        @(negedge S_AXI_ACLK);
        rd_req.arvalid = 1'b0;
        while (!rd_rsp.rvalid)
        begin
            @(negedge S_AXI_ACLK);
        end
        last_read.index    = idx;
        last_read.got      = rd_rsp.rdata;
        last_read.exp      = expected_read(idx, shadow, status);
        last_read.resp     = rd_rsp.rresp;
        last_read.ctrl_got = ctrl;
        last_read.ctrl_exp = expected_ctrl();
        -> read_ready;
        // A second address must wait for the pending response
        repeat (delay)
        begin
            rd_req.araddr  = {idx ^ 3'd1, 2'b00};
            rd_req.arvalid = 1'b1;
            @(negedge S_AXI_ACLK);
            if (rd_rsp.arready)
            begin
                bus_errors++;
                $display("FAILED %0t: read address accepted while rvalid was high", $time);
            end
        end
        rd_req.arvalid = 1'b0;
        rd_req.rready  = 1'b1;
        @(negedge S_AXI_ACLK);
        rd_req.rready = 1'b0;
        if (rd_rsp.rvalid)
        begin
            bus_errors++;
            $display("FAILED %0t: rvalid still high after the data was taken", $time);
        end
    endtask

    // --------------------
    // Compare and timeout
    // --------------------

    always @(read_ready)
    begin
        checks += 2;
        if (last_read.got !== last_read.exp || last_read.resp !== RESP_OKAY)
        begin
            cmp_errors++;
            $display("FAILED %0t: read index %0d gave %h resp %0d, expected %h OKAY",
                $time, last_read.index, last_read.got, last_read.resp, last_read.exp);
        end
        if (last_read.ctrl_got !== last_read.ctrl_exp)
        begin
            cmp_errors++;
            $display("FAILED %0t: ctrl %h, expected %h",
                $time, last_read.ctrl_got, last_read.ctrl_exp);
        end
    end

    always @(posedge S_AXI_ACLK)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    initial
    begin
        logic [31:0] rnd;
        reg_idx_e    idx;
        rng_state     = 32'h41e6_0b80;
        S_AXI_ARESETN = 1'b0;
        wr_req        = '0;
        rd_req        = '0;
        status        = '0;
        writable      = '{REG_CTRL, REG_ADDR, REG_CANARY, REG_PG_MODE, REG_PG_SEED};
        shadow        = '{default: '0};
        shadow[REG_ADDR]   = ADDR_RESET;
        shadow[REG_CANARY] = CANARY_RESET;
        repeat (10) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN   = 1'b1;
        status.txn_done = 1'b1;

        // Reset values on all eight slots
        for (int i = 0; i < 8; i++)
        begin
            axil_read(reg_idx_e'(3'(i)));
        end

        // Full words to each writable slot
        for (int n = 0; n < 20; n++)
        begin
            idx = writable[n % 5];
            axil_write(idx, next_random(), 4'hf);
            axil_read(idx);
        end

        // Partial words under random strobes
        for (int n = 0; n < 20; n++)
        begin
            rnd = next_random();
            idx = writable[int'(rnd[18:16]) % 5];
            axil_write(idx, next_random(), rnd[23:20]);
            axil_read(idx);
        end

        // Read-only slots ignore writes, flags follow the tester
        axil_write(REG_DONE, next_random(), 4'hf);
        axil_write(REG_ERROR, next_random(), 4'hf);
        axil_write(REG_UNUSED, next_random(), 4'hf);
        for (int s = 0; s < 4; s++)
        begin
            @(negedge S_AXI_ACLK);
            status = tester_status_t'(2'(s));
            axil_read(REG_DONE);
            axil_read(REG_ERROR);
            axil_read(REG_UNUSED);
        end

        // Mixed traffic
        for (int n = 0; n < 60; n++)
        begin
            rnd = next_random();
            idx = reg_idx_e'(rnd[26:24]);
            if (rnd[31])
            begin
                axil_write(idx, next_random(), rnd[23:20]);
            end
            else
            begin
                axil_read(idx);
            end
        end

        @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        $display("Checks: %0d, compare errors: %0d, bus errors: %0d, assertion errors: %0d",
            checks, cmp_errors, bus_errors, u_burst_tester_regs.u_props.fail_count);
        if (cmp_errors == 0 && bus_errors == 0
            && u_burst_tester_regs.u_props.fail_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/burst_tester_regs_props.sv
`timescale 1ns/1ps
`default_nettype none

module burst_tester_regs_props (
    input logic                   S_AXI_ACLK,
    input logic                   S_AXI_ARESETN,
    input axil_pkg::axil_wr_req_t wr_req,
    input axil_pkg::axil_wr_rsp_t wr_rsp,
    input axil_pkg::axil_rd_req_t rd_req,
    input axil_pkg::axil_rd_rsp_t rd_rsp
);

    int fail_count = 0;

    // --------------------
    // Write channel
    // --------------------

    // Address and data are taken as a pair
    ready_paired: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr_rsp.awready == wr_rsp.wready)
        else
        begin
            fail_count++;
            $error("awready and wready differ");
        end

    // Single-cycle ready pulse
    ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr_rsp.awready |=> !wr_rsp.awready)
        else
        begin
            fail_count++;
            $error("awready high for two cycles in a row");
        end

    bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid)
        else
        begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    // --------------------
    // Read channel
    // --------------------

    rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.rdata))
        else
        begin
            fail_count++;
            $error("rvalid or rdata changed before rready");
        end

    // One read in flight at a time
    ar_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rd_rsp.rvalid |-> !rd_rsp.arready)
        else
        begin
            fail_count++;
            $error("arready high while rvalid pending");
        end

endmodule

bind burst_tester_regs burst_tester_regs_props u_props (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_req        (wr_req),
    .wr_rsp        (wr_rsp),
    .rd_req        (rd_req),
    .rd_rsp        (rd_rsp)
);

`default_nettype wire

// File: hw/burst_tester_regs.sv
`timescale 1ns/1ps
`default_nettype none

module burst_tester_regs (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  axil_pkg::axil_wr_req_t          wr_req,
    output axil_pkg::axil_wr_rsp_t          wr_rsp,
    input  axil_pkg::axil_rd_req_t          rd_req,
    output axil_pkg::axil_rd_rsp_t          rd_rsp,
    input  tester_regs_pkg::tester_status_t status,
    output tester_regs_pkg::tester_ctrl_t   ctrl
);
    import axil_pkg::*;
    import tester_regs_pkg::*;

    // Accepted write beat into the bank
    reg_wr_t                reg_wr;
    // Read index out, read word back
    reg_idx_e               rd_index;
    logic [AXIL_DATA_W-1:0] rd_data;

    // --------------------
    // Bus channels
    // --------------------

    axil_write_channel u_write_channel (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_req        (wr_req),
        .wr_rsp        (wr_rsp),
        .reg_wr        (reg_wr)
    );

    axil_read_channel u_read_channel (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .rd_req        (rd_req),
        .rd_rsp        (rd_rsp),
        .rd_index      (rd_index),
        .rd_data       (rd_data)
    );

    // Register storage and tester levels
    tester_reg_bank u_reg_bank (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .status        (status),
        .ctrl          (ctrl)
    );

endmodule

`default_nettype wire

// File: hw/tester_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tester_reg_bank (
    input  logic                                S_AXI_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  tester_regs_pkg::reg_wr_t            reg_wr,
    input  tester_regs_pkg::reg_idx_e           rd_index,
    output logic [axil_pkg::AXIL_DATA_W-1:0]    rd_data,
    input  tester_regs_pkg::tester_status_t     status,
    output tester_regs_pkg::tester_ctrl_t       ctrl
);
    import axil_pkg::*;
    import tester_regs_pkg::*;

    // Stored registers
    logic [AXIL_DATA_W-1:0] ctrl_reg;
    logic [AXIL_DATA_W-1:0] addr_reg;
    logic [AXIL_DATA_W-1:0] canary_reg;
    logic [AXIL_DATA_W-1:0] mode_reg;
    logic [AXIL_DATA_W-1:0] seed_reg;

    // Merge new bytes where the strobe is set
    function automatic logic [AXIL_DATA_W-1:0] apply_strb(
        input logic [AXIL_DATA_W-1:0] old_word,
        input logic [AXIL_DATA_W-1:0] new_word,
        input logic [AXIL_STRB_W-1:0] strb
    );
        logic [AXIL_DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < AXIL_STRB_W; i++)
        begin
            if (strb[i])
            begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // --------------------
    // Write side
    // --------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            ctrl_reg   <= '0;
            addr_reg   <= ADDR_RESET;
            canary_reg <= CANARY_RESET;
            mode_reg   <= '0;
            seed_reg   <= '0;
        end
        else if (reg_wr.valid)
        begin
            case (reg_wr.index)
                REG_CTRL:    ctrl_reg   <= apply_strb(ctrl_reg, reg_wr.data, reg_wr.strb);
                REG_ADDR:    addr_reg   <= apply_strb(addr_reg, reg_wr.data, reg_wr.strb);
                REG_CANARY:  canary_reg <= apply_strb(canary_reg, reg_wr.data, reg_wr.strb);
                REG_PG_MODE: mode_reg   <= apply_strb(mode_reg, reg_wr.data, reg_wr.strb);
                REG_PG_SEED: seed_reg   <= apply_strb(seed_reg, reg_wr.data, reg_wr.strb);
                // Status and spare slots are read only
                default: ;
            endcase
        end
    end

    // --------------------
    // Read mux
    // --------------------

    always_comb
    begin
        case (rd_index)
            REG_CTRL:    rd_data = ctrl_reg;
            // Live flags from the burst master
            REG_DONE:    rd_data = AXIL_DATA_W'(status.txn_done);
            REG_ERROR:   rd_data = AXIL_DATA_W'(status.txn_error);
            REG_ADDR:    rd_data = addr_reg;
            REG_CANARY:  rd_data = canary_reg;
            REG_PG_MODE: rd_data = mode_reg;
            // Seed is write only, signature reads back instead
            REG_PG_SEED: rd_data = SIGNATURE;
            default:     rd_data = '0;
        endcase
    end

    // Tester control levels
    always_comb
    begin
        ctrl.init_txn  = ctrl_reg[0];
        ctrl.m_address = addr_reg;
        ctrl.pg_mode   = mode_reg[PG_MODE_W-1:0];
        ctrl.pg_seed   = seed_reg;
    end

endmodule

`default_nettype wire

// File: hw/axil_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_channel (
    input  logic                                S_AXI_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  axil_pkg::axil_rd_req_t              rd_req,
    output axil_pkg::axil_rd_rsp_t              rd_rsp,
    output tester_regs_pkg::reg_idx_e           rd_index,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]    rd_data
);
    import axil_pkg::*;
    import tester_regs_pkg::*;

    logic                   arready;
    logic                   rvalid;
    axil_resp_e             rresp;
    logic [AXIL_DATA_W-1:0] rdata;
    logic                   ar_start;
    logic                   rd_fire;

    // No new address while a response is pending
    assign ar_start = !arready && !rvalid && rd_req.arvalid;
    assign rd_fire  = arready && rd_req.arvalid && !rvalid;

    // --------------------
    // Address phase
    // --------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            arready <= 1'b0;
        end
        else
        begin
            arready <= ar_start;
        end
    end

    // Latched index feeds the bank read mux
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (ar_start)
        begin
            rd_index <= reg_idx_e'(rd_req.araddr[AXIL_ADDR_LSB +: REG_IDX_W]);
        end
    end

    // --------------------
    // Data phase
    // --------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end
        else if (rd_fire)
        begin
            rvalid <= 1'b1;
            rresp  <= RESP_OKAY;
        end
        else if (rvalid && rd_req.rready)
        begin
            rvalid <= 1'b0;
        end
    end

    // Data held until rready
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_fire)
        begin
            rdata <= rd_data;
        end
    end

    always_comb
    begin
        rd_rsp.arready = arready;
        rd_rsp.rdata   = rdata;
        rd_rsp.rvalid  = rvalid;
        rd_rsp.rresp   = rresp;
    end

endmodule

`default_nettype wire

// File: hw/axil_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_channel (
    input  logic                        S_AXI_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  axil_pkg::axil_wr_req_t      wr_req,
    output axil_pkg::axil_wr_rsp_t      wr_rsp,
    output tester_regs_pkg::reg_wr_t    reg_wr
);
    import axil_pkg::*;
    import tester_regs_pkg::*;

    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_e bresp;
    // High while no write is outstanding
    logic       aw_en;
    reg_idx_e   aw_index;
    logic       wr_start;
    logic       wr_fire;

    // Address and data must arrive together
    assign wr_start = !awready && wr_req.awvalid && wr_req.wvalid && aw_en;
    // Beat is taken in the ready cycle
    assign wr_fire  = awready && wr_req.awvalid && wready && wr_req.wvalid;

    // --------------------
    // Acceptance
    // --------------------

    // Paired one-cycle ready pulse
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_en   <= 1'b1;
        end
        else if (wr_start)
        begin
            awready <= 1'b1;
            wready  <= 1'b1;
            aw_en   <= 1'b0;
        end
        else
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            // Reopen only once the response is taken
            if (wr_req.bready && bvalid)
            begin
                aw_en <= 1'b1;
            end
        end
    end

    // Keep just the word index
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_start)
        begin
            aw_index <= reg_idx_e'(wr_req.awaddr[AXIL_ADDR_LSB +: REG_IDX_W]);
        end
    end

    // --------------------
    // Response
    // --------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end
        else if (wr_fire && !bvalid)
        begin
            bvalid <= 1'b1;
            bresp  <= RESP_OKAY;
        end
        else if (wr_req.bready && bvalid)
        begin
            bvalid <= 1'b0;
        end
    end

    // Bus outputs and the write strobe to the bank
    always_comb
    begin
        wr_rsp.awready = awready;
        wr_rsp.wready  = wready;
        wr_rsp.bvalid  = bvalid;
        wr_rsp.bresp   = bresp;
        reg_wr.valid   = wr_fire;
        reg_wr.index   = aw_index;
        reg_wr.data    = wr_req.wdata;
        reg_wr.strb    = wr_req.wstrb;
    end

endmodule

`default_nettype wire

// File: hw/tester_regs_pkg.sv
`default_nettype none

package tester_regs_pkg;

    // --------------------
    // Register map
    // --------------------

    // Eight word registers
    localparam int REG_IDX_W = 3;

    typedef enum logic [REG_IDX_W-1:0] {
        REG_CTRL    = 3'd0,
        REG_DONE    = 3'd1,
        REG_ERROR   = 3'd2,
        REG_ADDR    = 3'd3,
        REG_CANARY  = 3'd4,
        REG_UNUSED  = 3'd5,
        REG_PG_MODE = 3'd6,
        REG_PG_SEED = 3'd7
    } reg_idx_e;

    // Default test base address
    localparam logic [axil_pkg::AXIL_DATA_W-1:0] ADDR_RESET   = 32'hfffc0000;
    // Known word so software can spot a live block
    localparam logic [axil_pkg::AXIL_DATA_W-1:0] CANARY_RESET = 32'hdeadfeed;
    // Returned in place of the seed on reads
    localparam logic [axil_pkg::AXIL_DATA_W-1:0] SIGNATURE    = 32'hfeedbeef;

    // Pattern generator mode field
    localparam int PG_MODE_W = 2;

    // --------------------
    // Internal and tester bundles
    // --------------------

    // One accepted write beat, valid for a single cycle
    typedef struct packed {
        logic                               valid;
        reg_idx_e                           index;
        logic [axil_pkg::AXIL_DATA_W-1:0]   data;
        logic [axil_pkg::AXIL_STRB_W-1:0]   strb;
    } reg_wr_t;

    // To the burst master
    typedef struct packed {
        logic                               init_txn;
        logic [axil_pkg::AXIL_DATA_W-1:0]   m_address;
        logic [PG_MODE_W-1:0]               pg_mode;
        logic [axil_pkg::AXIL_DATA_W-1:0]   pg_seed;
    } tester_ctrl_t;

    // From the burst master
    typedef struct packed {
        logic txn_done;
        logic txn_error;
    } tester_status_t;

endpackage

`default_nettype wire

// File: hw/axil_pkg.sv
`default_nettype none

package axil_pkg;

    // --------------------
    // Bus widths
    // --------------------

    // Byte address covers eight 32-bit registers
    localparam int AXIL_ADDR_W   = 5;
    localparam int AXIL_DATA_W   = 32;
    localparam int AXIL_STRB_W   = AXIL_DATA_W / 8;
    // Lowest address bit that selects a word
    localparam int AXIL_ADDR_LSB = 2;

    // Response codes as on the bus
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    // --------------------
    // Channel bundles
    // --------------------

    // Write side, master to slave
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
    } axil_wr_req_t;

    // Write side, slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_e bresp;
    } axil_wr_rsp_t;

    // Read side, master to slave
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_rd_req_t;

    // Read side, slave to master
    typedef struct packed {
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic                   rvalid;
        axil_resp_e             rresp;
    } axil_rd_rsp_t;

endpackage

`default_nettype wire
